// File: zx_defines.svh
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

// bus widths
`define ZX_ADDR_W 16
`define ZX_DATA_W 8

// #FE decodes on the low byte only
`define ZX_PORT_ULA     16'h00FE
`define ZX_PORT_SYSCONF 16'h20AF
`define ZX_PORT_INTMASK 16'h2AAF

// im2 vectors
`define ZX_VECT_FRAME 8'hFF
`define ZX_VECT_LINE  8'hFD

// short simulation periods in fclk cycles
`define ZX_LINE_CLKS  256
`define ZX_FRAME_CLKS 2048 // whole number of lines
`define ZX_INT_CLKS   64

`endif

// File: zx_pkg.sv
`default_nettype none

`include "zx_defines.svh"

package zx_pkg;

  // z80 address and data
  typedef logic [`ZX_ADDR_W-1:0] zaddr_t;
  typedef logic [`ZX_DATA_W-1:0] zdata_t; // also port regs and vectors

  // interrupt enables
  typedef logic [1:0] intmask_t; // bit 0 frame, bit 1 line

  // cpu clock rate in sysconf bits 1:0
  typedef enum logic [1:0] {
    turbo_3m5 = 2'd0,
    turbo_7m  = 2'd1,
    turbo_14m = 2'd2
  } turbo_t;

endpackage

`default_nettype wire

// File: zx_clock.sv
`timescale 1ns/1ps
`default_nettype none

module zx_clock import zx_pkg::*; (
  input  logic   fclk,
  input  logic   rst_n,
  input  turbo_t turbo,
  output logic   c0,
  output logic   c1,
  output logic   c2,
  output logic   c3,
  output logic   clkz_out,
  output logic   zpos,
  output logic   zneg
);

  logic [1:0] phase;
  logic [1:0] div;       // fclk left in this half period
  logic [1:0] half_last; // half period minus one
  turbo_t     turbo_r;
  logic       tick;

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  assign c0 = (phase == 2'd0);
  assign c1 = (phase == 2'd1);
  assign c2 = (phase == 2'd2);
  assign c3 = (phase == 2'd3);

  // rate change only lands on c0 so the divider stays phase aligned
  always_comb begin
    case (c0 ? turbo : turbo_r)
      turbo_3m5: half_last = 2'd3;
      turbo_7m:  half_last = 2'd1;
      turbo_14m: half_last = 2'd0;
      default:   half_last = 2'd0;
    endcase
  end

  assign tick = (div == 2'd0);

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      turbo_r  <= turbo_3m5;
      div      <= 2'd0;
      clkz_out <= 1'b0;
      zpos     <= 1'b0;
      zneg     <= 1'b0;
    end else begin
      zpos <= tick & ~clkz_out; // high with the new level
      zneg <= tick & clkz_out;
      if (tick)
        clkz_out <= ~clkz_out;
      if (c0)
        turbo_r <= turbo;
      if (c0 || tick)
        div <= half_last;
      else
        div <= div - 2'd1;
    end
  end

endmodule

`default_nettype wire

// File: z80_signals.sv
`timescale 1ns/1ps
`default_nettype none

module z80_signals import zx_pkg::*; (
  input  logic fclk,
  input  logic rst_n,
  input  logic c3,
  input  logic iorq_n,
  input  logic rd_n,
  input  logic wr_n,
  input  logic m1_n,
  output logic iord,
  output logic iowr,
  output logic intack,
  output logic iowr_s
);

  logic [1:0] iorq_sr;
  logic [1:0] rd_sr;
  logic [1:0] wr_sr;
  logic [1:0] m1_sr;
  logic       iorq;
  logic       iowr_d;
  logic       wr_pend; // write seen and waiting for c3

  // two-flop sync with high idle level
  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      iorq_sr <= 2'b11;
      rd_sr   <= 2'b11;
      wr_sr   <= 2'b11;
      m1_sr   <= 2'b11;
    end else begin
      iorq_sr <= {iorq_sr[0], iorq_n};
      rd_sr   <= {rd_sr[0], rd_n};
      wr_sr   <= {wr_sr[0], wr_n};
      m1_sr   <= {m1_sr[0], m1_n};
    end
  end

  assign iorq   = ~iorq_sr[1];
  assign iord   = iorq & ~rd_sr[1];
  assign iowr   = iorq & ~wr_sr[1];
  assign intack = iorq & ~m1_sr[1];

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      iowr_d  <= 1'b0;
      wr_pend <= 1'b0;
    end else begin
      iowr_d <= iowr;
      if (iowr && !iowr_d)
        wr_pend <= 1'b1;
      else if (c3)
        wr_pend <= 1'b0;
    end
  end

  assign iowr_s = c3 & wr_pend; // once per io write

endmodule

`default_nettype wire

// File: zx_ports.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_defines.svh"

module zx_ports import zx_pkg::*; (
  input  logic     fclk,
  input  logic     rst_n,
  input  logic     iord,
  input  logic     iowr_s,
  input  zaddr_t   a,
  input  zdata_t   zd_in,
  input  logic     tape_in,
  output zdata_t   port_dout,
  output logic     port_oe,
  output turbo_t   turbo,
  output intmask_t intmask,
  output logic     beep
);

  localparam zaddr_t port_ula     = `ZX_PORT_ULA;
  localparam zaddr_t port_sysconf = `ZX_PORT_SYSCONF;
  localparam zaddr_t port_intmask = `ZX_PORT_INTMASK;

  logic       hit_ula;
  logic       hit_sysconf;
  logic       hit_intmask;
  logic       tapeout;
  logic       beeper;
  logic       beeper_mux;  // set routes tapeout to the speaker
  logic       tape_sound;  // tape input monitor
  logic [1:0] tape_sr;
  logic       tape_s;
  logic       snd_src;
  zdata_t     rd_mux;

  assign hit_ula     = (a[7:0] == port_ula[7:0]);
  assign hit_sysconf = (a == port_sysconf);
  assign hit_intmask = (a == port_intmask);

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      tapeout    <= 1'b0;
      beeper     <= 1'b0;
      turbo      <= turbo_3m5;
      beeper_mux <= 1'b0;
      tape_sound <= 1'b0;
      intmask    <= 2'b01; // frame int only
    end else if (iowr_s) begin
      if (hit_ula) begin
        tapeout <= zd_in[3];
        beeper  <= zd_in[4];
      end
      if (hit_sysconf) begin
        turbo      <= turbo_t'(zd_in[1:0]);
        beeper_mux <= zd_in[2];
        tape_sound <= zd_in[3];
      end
      if (hit_intmask)
        intmask <= intmask_t'(zd_in[1:0]);
    end
  end

  // tape input is asynchronous
  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n)
      tape_sr <= 2'b00;
    else
      tape_sr <= {tape_sr[0], tape_in};
  end

  assign tape_s = tape_sr[1];

  always_comb begin
    if (hit_ula)
      rd_mux = {1'b1, tape_s, 6'h3f};
    else if (hit_sysconf)
      rd_mux = {4'h0, tape_sound, beeper_mux, turbo};
    else
      rd_mux = {6'h00, intmask};
  end

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n)
      port_oe <= 1'b0;
    else
      port_oe <= iord & (hit_ula | hit_sysconf | hit_intmask);
  end

  always_ff @(posedge fclk) begin
    port_dout <= rd_mux;
  end

  // sound mixer
  assign snd_src = beeper_mux ? tapeout : beeper;

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n)
      beep <= 1'b0;
    else
      beep <= snd_src ^ (tape_sound & tape_s);
  end

endmodule

`default_nettype wire

// File: zx_int.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_defines.svh"

module zx_int import zx_pkg::*; (
  input  logic     fclk,
  input  logic     rst_n,
  input  logic     intack,
  input  intmask_t intmask,
  output logic     int_n,
  output zdata_t   im2vect
);

  localparam int frm_w = $clog2(`ZX_FRAME_CLKS);
  localparam int lin_w = $clog2(`ZX_LINE_CLKS);
  localparam int pls_w = $clog2(`ZX_INT_CLKS);

  localparam logic [frm_w-1:0] frm_last = frm_w'(`ZX_FRAME_CLKS - 1);
  localparam logic [lin_w-1:0] lin_last = lin_w'(`ZX_LINE_CLKS - 1);
  localparam logic [pls_w-1:0] pls_last = pls_w'(`ZX_INT_CLKS - 1);

  logic [frm_w-1:0] frm_cnt;
  logic [lin_w-1:0] lin_cnt;
  logic [pls_w-1:0] pls_cnt;
  logic             start_frm;
  logic             start_lin;

  assign start_frm = (frm_cnt == frm_last) & intmask[0];
  assign start_lin = (lin_cnt == lin_last) & intmask[1];

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      frm_cnt <= '0;
      lin_cnt <= '0;
      pls_cnt <= '0;
      int_n   <= 1'b1;
    end else begin
      frm_cnt <= (frm_cnt == frm_last) ? '0 : frm_cnt + 1'b1;
      lin_cnt <= (lin_cnt == lin_last) ? '0 : lin_cnt + 1'b1;
      if (int_n) begin
        if (start_frm || start_lin) begin
          int_n   <= 1'b0;
          pls_cnt <= pls_last;
        end
      end else if (intack || pls_cnt == '0) begin
        int_n <= 1'b1; // starts while low are lost
      end else begin
        pls_cnt <= pls_cnt - 1'b1;
      end
    end
  end

  // frame wins a tie
  always_ff @(posedge fclk) begin
    if (int_n && (start_frm || start_lin))
      im2vect <= start_frm ? `ZX_VECT_FRAME : `ZX_VECT_LINE;
  end

endmodule

`default_nettype wire

// File: zx_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_top import zx_pkg::*; (
  input  logic   fclk,
  input  logic   rst_n,
  input  logic   iorq_n,
  input  logic   rd_n,
  input  logic   wr_n,
  input  logic   m1_n,
  input  zaddr_t a,
  input  zdata_t zd_in,
  input  logic   tape_in,
  output zdata_t zd_out,
  output logic   zd_oe,
  output logic   clkz_out,
  output logic   int_n,
  output logic   beep
);

  logic     c3;
  logic     iord;
  logic     intack;
  logic     iowr_s;
  turbo_t   turbo;
  intmask_t intmask;
  zdata_t   port_dout;
  logic     port_oe;
  zdata_t   im2vect;

  zx_clock u_clock (
    .fclk     (fclk),
    .rst_n    (rst_n),
    .turbo    (turbo),
    .c0       (),
    .c1       (),
    .c2       (),
    .c3       (c3),
    .clkz_out (clkz_out),
    .zpos     (),
    .zneg     ()
  );

  z80_signals u_sig (
    .fclk   (fclk),
    .rst_n  (rst_n),
    .c3     (c3),
    .iorq_n (iorq_n),
    .rd_n   (rd_n),
    .wr_n   (wr_n),
    .m1_n   (m1_n),
    .iord   (iord),
    .iowr   (),
    .intack (intack),
    .iowr_s (iowr_s)
  );

  zx_ports u_ports (
    .fclk      (fclk),
    .rst_n     (rst_n),
    .iord      (iord),
    .iowr_s    (iowr_s),
    .a         (a),
    .zd_in     (zd_in),
    .tape_in   (tape_in),
    .port_dout (port_dout),
    .port_oe   (port_oe),
    .turbo     (turbo),
    .intmask   (intmask),
    .beep      (beep)
  );

  zx_int u_int (
    .fclk    (fclk),
    .rst_n   (rst_n),
    .intack  (intack),
    .intmask (intmask),
    .int_n   (int_n),
    .im2vect (im2vect)
  );

  // vector has priority on the bus
  assign zd_out = intack ? im2vect : port_dout;
  assign zd_oe  = intack | port_oe;

endmodule

`default_nettype wire

// File: tb_zx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_defines.svh"

module tb_zx_top import zx_pkg::*; ();

  logic        fclk = 1'b0;
  logic        rst_n;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  zaddr_t      a;
  zdata_t      zd_in;
  logic        tape_in;
  zdata_t      zd_out;
  logic        zd_oe;
  logic        clkz_out;
  logic        int_n;
  logic        beep;
  logic [31:0] lfsr;

  zx_top u_zx_top (
    .fclk     (fclk),
    .rst_n    (rst_n),
    .iorq_n   (iorq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .m1_n     (m1_n),
    .a        (a),
    .zd_in    (zd_in),
    .tape_in  (tape_in),
    .zd_out   (zd_out),
    .zd_oe    (zd_oe),
    .clkz_out (clkz_out),
    .int_n    (int_n),
    .beep     (beep)
  );

  initial begin
    forever #2 fclk = ~fclk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]}; // one step per bit
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual)
    else begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic timeout_stop(input string what);
    $display("sim failed");
    $fatal(1, "timeout: %s", what);
  endtask

  task automatic io_write(input zaddr_t addr, input zdata_t data);
    @(negedge fclk);
    a      = addr;
    zd_in  = data;
    iorq_n = 1'b0;
    wr_n   = 1'b0;
    repeat (16) @(negedge fclk);
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    repeat (4) @(negedge fclk);
  endtask

  task automatic io_read(input zaddr_t addr, output zdata_t data);
    int n;
    @(negedge fclk);
    a      = addr;
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    n      = 0;
    while (!zd_oe) begin
      @(negedge fclk);
      n++;
      if (n > 8)
        timeout_stop("read data never driven on the bus");
    end
    data   = zd_out;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    repeat (4) @(negedge fclk);
  endtask

  // acknowledge the pending interrupt and check the vector
  task automatic int_ack(input zdata_t vect, input string name);
    int n;
    n = 0;
    while (int_n) begin
      @(negedge fclk);
      n++;
      if (n > 2 * `ZX_FRAME_CLKS)
        timeout_stop("int_n never went low");
    end
    iorq_n = 1'b0;
    m1_n   = 1'b0;
    n      = 0;
    while (!int_n && n < 6) begin
      @(negedge fclk);
      n++;
    end
    check_value("int_n after ack", 1, int'(int_n));
    check_value("ack bus enable", 1, int'(zd_oe));
    check_value(name, int'(vect), int'(zd_out));
    iorq_n = 1'b1;
    m1_n   = 1'b1;
    repeat (4) @(negedge fclk);
  endtask

  // fclk cycles until the next rising edge of clkz_out
  task automatic clkz_period(output int n);
    logic prev;
    logic rose;
    prev = clkz_out;
    n    = 0;
    do begin
      @(negedge fclk);
      n++;
      if (n > 32)
        timeout_stop("clkz_out stopped toggling");
      rose = ~prev & clkz_out;
      prev = clkz_out;
    end while (!rose);
  endtask

  // fclk cycles until the next falling edge of int_n
  task automatic int_spacing(output int n);
    logic prev;
    logic fell;
    prev = int_n;
    n    = 0;
    do begin
      @(negedge fclk);
      n++;
      if (n > 2 * `ZX_FRAME_CLKS + 128)
        timeout_stop("no falling edge on int_n");
      fell = prev & ~int_n;
      prev = int_n;
    end while (!fell);
  endtask

  initial begin
    zdata_t d;
    zdata_t hi;
    zdata_t s;
    zdata_t t;
    zdata_t rd;
    int     n;
    logic   exp_beep;
    lfsr    = 32'hd558_e76e;
    rst_n   = 1'b0;
    iorq_n  = 1'b1;
    rd_n    = 1'b1;
    wr_n    = 1'b1;
    m1_n    = 1'b1;
    a       = '0;
    zd_in   = '0;
    tape_in = 1'b0;
    repeat (10) @(negedge fclk);
    rst_n = 1'b1;
    repeat (2) @(negedge fclk);

    check_value("reset int_n", 1, int'(int_n));
    check_value("reset zd_oe", 0, int'(zd_oe));
    io_read(`ZX_PORT_SYSCONF, rd);
    check_value("reset sysconf", 0, int'(rd));
    io_read(`ZX_PORT_INTMASK, rd);
    check_value("reset intmask", 1, int'(rd));

    for (int i = 0; i < 8; i++) begin
      rand_bits(8, d);
      io_write(`ZX_PORT_SYSCONF, d);
      io_read(`ZX_PORT_SYSCONF, rd);
      check_value("sysconf read", int'(d & 8'h0f), int'(rd));
      rand_bits(8, d);
      io_write(`ZX_PORT_INTMASK, d);
      io_read(`ZX_PORT_INTMASK, rd);
      check_value("intmask read", int'(d & 8'h03), int'(rd));
    end

    for (int i = 0; i < 3; i++) begin
      io_write(`ZX_PORT_SYSCONF, 8'(i));
      clkz_period(n); // first one may be partial
      clkz_period(n);
      check_value("clkz period", 8 >> i, n);
    end

    for (int i = 0; i < 12; i++) begin
      rand_bits(8, d);
      rand_bits(8, hi);
      io_write({hi, 8'hfe}, d); // high byte not decoded
      rand_bits(2, s);
      io_write(`ZX_PORT_SYSCONF, {4'h0, s[1:0], 2'b00});
      rand_bits(1, t);
      tape_in  = t[0];
      exp_beep = (s[0] ? d[3] : d[4]) ^ (s[1] & t[0]);
      n        = 0;
      while (beep !== exp_beep && n < 8) begin
        @(negedge fclk);
        n++;
      end
      check_value("beep", int'(exp_beep), int'(beep));
      io_read({hi, 8'hfe}, rd);
      check_value("ula read", int'({1'b1, t[0], 6'h3f}), int'(rd));
    end

    io_write(`ZX_PORT_INTMASK, 8'h01);
    int_spacing(n);
    int_spacing(n);
    check_value("frame spacing", `ZX_FRAME_CLKS, n);
    int_ack(`ZX_VECT_FRAME, "frame vector");

    io_write(`ZX_PORT_INTMASK, 8'h02);
    int_spacing(n);
    int_spacing(n);
    check_value("line spacing", `ZX_LINE_CLKS, n);
    int_ack(`ZX_VECT_LINE, "line vector");

    // all sources masked
    io_write(`ZX_PORT_INTMASK, 8'h00);
    n = 0;
    while (!int_n) begin
      @(negedge fclk);
      n++;
      if (n > `ZX_INT_CLKS + 8)
        timeout_stop("int_n stuck low after masking");
    end
    for (int i = 0; i < 2 * `ZX_FRAME_CLKS; i++) begin
      @(negedge fclk);
      check_value("masked int_n", 1, int'(int_n));
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
zx_pkg.sv
zx_clock.sv
z80_signals.sv
zx_ports.sv
zx_int.sv
zx_top.sv
tb_zx_top.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_zx_top
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
